/* hw/rab_bus_pkg.sv */
/* Bus side definitions for the RAB configuration port: AXI-Lite widths,
   response codes and the internal write request into the slice table. */
`default_nettype none

package rab_bus_pkg;

  localparam int unsigned AXI_DATA_WIDTH = 64;
  localparam int unsigned AXI_ADDR_WIDTH = 32;
  localparam int unsigned AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Index of a 64-bit slice word inside the 16 KiB L1 region
  localparam int unsigned CFG_IDX_WIDTH = 11;

  typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
  typedef logic [CFG_IDX_WIDTH-1:0]  cfg_idx_t;

  // One accepted write, valid for a single cycle
  typedef struct packed {
    logic      en;
    cfg_idx_t  idx;
    axi_data_t data;
    axi_strb_t strb;
  } cfg_wr_req_t;

endpackage

`default_nettype wire

/* hw/rab_cfg_pkg.sv */
/* Configuration map of the RAB: address regions, slot kinds of the slice words,
   the three views of a stored word and the layout of a queued miss. */
`default_nettype none

package rab_cfg_pkg;

  localparam int unsigned WORD_BYTES = 8;
  localparam int unsigned WORD_LSB   = 3;  // Byte offset bits of a word address

  localparam logic [31:0] L1_REGION_SIZE = 32'h0000_4000;
  localparam logic [31:0] MISS_ADDR_REG  = 32'h0000_4000;
  localparam logic [31:0] MISS_ID_REG    = 32'h0000_4008;

  localparam int unsigned ADDR_WIDTH_VIRT_MAX = 32;
  localparam int unsigned ADDR_WIDTH_PHYS_MAX = 48;
  localparam int unsigned MISS_ID_WIDTH       = 10;

  localparam int unsigned MISS_EMPTY_BIT = 63;

  // Index bits 00 and 01 both hold a virtual address
  typedef enum logic [1:0] {
    SLOT_VIRT  = 2'b00,
    SLOT_PHYS  = 2'b10,
    SLOT_FLAGS = 2'b11
  } slot_kind_e;

  typedef struct packed {
    logic [63-ADDR_WIDTH_VIRT_MAX:0] pad;
    logic [ADDR_WIDTH_VIRT_MAX-1:0]  addr;
  } virt_view_t;

  typedef struct packed {
    logic [63-ADDR_WIDTH_PHYS_MAX:0] pad;
    logic [ADDR_WIDTH_PHYS_MAX-1:0]  addr;
  } phys_view_t;

  typedef struct packed {
    logic [55:0] pad;
    logic [7:0]  flags;
  } flags_view_t;

  // Same 64 bits, decoded according to the slot kind
  typedef union packed {
    virt_view_t  virt;
    phys_view_t  phys;
    flags_view_t flags;
  } cfg_word_u;

  typedef struct packed {
    logic [ADDR_WIDTH_VIRT_MAX-1:0] addr;
    logic [MISS_ID_WIDTH-1:0]       id;
  } miss_entry_t;

  function automatic slot_kind_e slot_kind_of(logic [1:0] idx_lsb);
    slot_kind_e kind;
    case (idx_lsb)
      2'b10:   kind = SLOT_PHYS;
      2'b11:   kind = SLOT_FLAGS;
      default: kind = SLOT_VIRT;
    endcase
    return kind;
  endfunction

endpackage

`default_nettype wire

/* hw/rab_fifo_ptr.sv */
/* Pointer and occupancy bookkeeping for the miss queue. Pointers wrap
   naturally, so the depth must be a power of two. */
`timescale 1ns/1ps
`default_nettype none

module rab_fifo_ptr #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                          Clk_CI,
  input  logic                          Rst_RBI,
  input  logic                          push_i,
  input  logic                          pop_i,
  output logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_o,
  output logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_o,
  output logic                          full_o,
  output logic                          empty_o
);
  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;   // One bit wider to tell full from empty

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  assign wr_ptr_o = wr_ptr_q;
  assign rd_ptr_o = rd_ptr_q;
  assign full_o   = (count_q == (PTR_W+1)'(FIFO_DEPTH));
  assign empty_o  = (count_q == '0);

  a_no_overflow: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    push_i |-> !full_o)
    else $error("Miss pushed into a full queue");

  a_no_underflow: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    pop_i |-> !empty_o)
    else $error("Miss popped from an empty queue");

endmodule

`default_nettype wire

/* hw/rab_miss_fifo.sv */
/* Queue of translation misses. Accepts entries by valid/ready and shows the
   oldest entry at its head until software pops it. */
`timescale 1ns/1ps
`default_nettype none

module rab_miss_fifo #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                     Clk_CI,
  input  logic                     Rst_RBI,
  input  logic                     miss_valid_i,
  input  rab_cfg_pkg::miss_entry_t miss_i,
  output logic                     miss_ready_o,
  input  logic                     pop_i,
  output rab_cfg_pkg::miss_entry_t head_o,
  output logic                     empty_o
);
  import rab_cfg_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  miss_entry_t      mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             push;

  assign miss_ready_o = ~full;  // Source holds its miss while full
  assign push         = miss_valid_i & miss_ready_o;

  always_ff @(posedge Clk_CI)
  begin
    if (push)
      mem_q[wr_ptr] <= miss_i;
  end

  assign head_o = mem_q[rd_ptr];

  rab_fifo_ptr #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo_ptr (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .push_i   (push),
    .pop_i    (pop_i),
    .wr_ptr_o (wr_ptr),
    .rd_ptr_o (rd_ptr),
    .full_o   (full),
    .empty_o  (empty_o)
  );

endmodule

`default_nettype wire

/* hw/rab_cfg_regfile.sv */
/* L1 slice table of the RAB. Applies strobed writes, trims each word to the
   bits its slot kind can hold and drives all words out in parallel. */
`timescale 1ns/1ps
`default_nettype none

module rab_cfg_regfile #(
  parameter int unsigned N_REGS          = 16,
  parameter int unsigned ADDR_WIDTH_VIRT = 32,
  parameter int unsigned ADDR_WIDTH_PHYS = 40,
  parameter int unsigned N_FLAGS         = 4
) (
  input  logic                                Clk_CI,
  input  logic                                Rst_RBI,
  input  rab_bus_pkg::cfg_wr_req_t            wr_req_i,
  input  rab_bus_pkg::cfg_idx_t               rd_idx_i,
  output rab_cfg_pkg::cfg_word_u              rd_word_o,
  output rab_cfg_pkg::cfg_word_u [N_REGS-1:0] l1_cfg_o
);
  import rab_bus_pkg::*;
  import rab_cfg_pkg::*;

  // Bits a slot of the given kind keeps
  function automatic cfg_word_u kind_mask(slot_kind_e kind);
    cfg_word_u m;
    m = '0;
    case (kind)
      SLOT_VIRT: m.virt.addr = ADDR_WIDTH_VIRT_MAX'((64'd1 << ADDR_WIDTH_VIRT) - 64'd1);
      SLOT_PHYS: m.phys.addr = ADDR_WIDTH_PHYS_MAX'((64'd1 << ADDR_WIDTH_PHYS) - 64'd1);
      default:   m.flags.flags = 8'((64'd1 << N_FLAGS) - 64'd1);
    endcase
    return m;
  endfunction

  for (genvar i = 0; i < N_REGS; i++)
  begin : g_word
    localparam cfg_word_u KEEP = kind_mask(slot_kind_of(2'(i % 4)));

    cfg_word_u word_q;
    cfg_word_u merged;

    // Byte lanes without strobe keep their old value
    always_comb
    begin
      merged = word_q;
      for (int b = 0; b < WORD_BYTES; b++)
      begin
        if (wr_req_i.strb[b])
          merged[8*b +: 8] = wr_req_i.data[8*b +: 8];
      end
    end

    always_ff @(posedge Clk_CI or negedge Rst_RBI)
    begin
      if (!Rst_RBI)
        word_q <= '0;
      else if (wr_req_i.en && (wr_req_i.idx == CFG_IDX_WIDTH'(i)))
        word_q <= merged & KEEP;
    end

    assign l1_cfg_o[i] = word_q;
  end

  assign rd_word_o = l1_cfg_o[rd_idx_i];  // Range checked by the controller

endmodule

`default_nettype wire

/* hw/rab_cfg_axi_ctrl.sv */
/* AXI-Lite slave control for the RAB configuration port. Runs the write and
   read handshakes, issues slice table writes and selects the read data. */
`timescale 1ns/1ps
`default_nettype none

module rab_cfg_axi_ctrl #(
  parameter int unsigned N_REGS          = 16,
  parameter int unsigned ADDR_WIDTH_VIRT = 32
) (
  input  logic                     Clk_CI,
  input  logic                     Rst_RBI,
  // Write channels
  input  rab_bus_pkg::axi_addr_t   awaddr_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  rab_bus_pkg::axi_data_t   wdata_i,
  input  rab_bus_pkg::axi_strb_t   wstrb_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  output logic                     bvalid_o,
  output logic [1:0]               bresp_o,
  input  logic                     bready_i,
  // Read channels
  input  rab_bus_pkg::axi_addr_t   araddr_i,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  output logic                     rvalid_o,
  output rab_bus_pkg::axi_data_t   rdata_o,
  output logic [1:0]               rresp_o,
  input  logic                     rready_i,
  // Slice table
  output rab_bus_pkg::cfg_wr_req_t wr_req_o,
  output rab_bus_pkg::cfg_idx_t    rd_idx_o,
  input  rab_cfg_pkg::cfg_word_u   rd_word_i,
  // Miss queue
  input  rab_cfg_pkg::miss_entry_t miss_head_i,
  input  logic                     miss_empty_i,
  output logic                     miss_pop_o
);
  import rab_bus_pkg::*;
  import rab_cfg_pkg::*;

  typedef enum logic [1:0] {W_IDLE, W_COLLECT, W_RESP} wr_state_e;
  typedef enum logic {R_IDLE, R_RESP} rd_state_e;

  wr_state_e wr_state_q;
  rd_state_e rd_state_q;
  logic      aw_held_q;
  logic      w_held_q;
  logic      ar_held_q;
  axi_addr_t aw_addr_q;
  axi_addr_t ar_addr_q;
  axi_data_t w_data_q;
  axi_strb_t w_strb_q;
  axi_data_t rdata_q;
  axi_data_t rdata_d;
  cfg_idx_t  wr_idx;
  logic      aw_hs;
  logic      w_hs;
  logic      b_hs;
  logic      ar_hs;
  logic      r_hs;
  logic      wr_fire;
  logic      rd_load;

  assign aw_hs   = awvalid_i & awready_o;
  assign w_hs    = wvalid_i & wready_o;
  assign b_hs    = bvalid_o & bready_i;
  assign ar_hs   = arvalid_i & arready_o;
  assign r_hs    = rvalid_o & rready_i;
  assign wr_fire = aw_held_q & w_held_q & (wr_state_q == W_COLLECT);  // Both halves in hand
  assign rd_load = ar_held_q & (rd_state_q == R_IDLE);

  assign awready_o = ~aw_held_q;
  assign wready_o  = ~w_held_q;
  assign bvalid_o  = (wr_state_q == W_RESP);
  assign bresp_o   = RESP_OKAY;    // Unmapped writes are dropped silently
  assign arready_o = ~ar_held_q;
  assign rvalid_o  = (rd_state_q == R_RESP);
  assign rresp_o   = RESP_OKAY;
  assign rdata_o   = rdata_q;

  assign wr_idx        = aw_addr_q[WORD_LSB +: CFG_IDX_WIDTH];
  assign wr_req_o.en   = wr_fire && (aw_addr_q < L1_REGION_SIZE) && (wr_idx < N_REGS);
  assign wr_req_o.idx  = wr_idx;
  assign wr_req_o.data = w_data_q;
  assign wr_req_o.strb = w_strb_q;

  assign rd_idx_o   = ar_addr_q[WORD_LSB +: CFG_IDX_WIDTH];
  // Only an ID read that returned an entry consumes the head
  assign miss_pop_o = r_hs & (ar_addr_q == MISS_ID_REG) & ~rdata_q[MISS_EMPTY_BIT];

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_state_q <= W_IDLE;
      aw_held_q  <= 1'b0;
      w_held_q   <= 1'b0;
    end
    else
    begin
      case (wr_state_q)
        W_IDLE, W_COLLECT:
        begin
          if (aw_hs)
            aw_held_q <= 1'b1;
          if (w_hs)
            w_held_q <= 1'b1;
          if (wr_fire)
            wr_state_q <= W_RESP;  // Table written at this edge
          else if (aw_hs || w_hs)
            wr_state_q <= W_COLLECT;
        end
        W_RESP:
        begin
          if (b_hs)
          begin
            wr_state_q <= W_IDLE;
            aw_held_q  <= 1'b0;
            w_held_q   <= 1'b0;
          end
        end
        default: wr_state_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      rd_state_q <= R_IDLE;
      ar_held_q  <= 1'b0;
    end
    else if (rd_state_q == R_IDLE)
    begin
      if (ar_hs)
        ar_held_q <= 1'b1;
      if (rd_load)
        rd_state_q <= R_RESP;
    end
    else if (r_hs)
    begin
      rd_state_q <= R_IDLE;
      ar_held_q  <= 1'b0;
    end
  end

  // Payload registers
  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      aw_addr_q <= awaddr_i;
    if (w_hs)
    begin
      w_data_q <= wdata_i;
      w_strb_q <= wstrb_i;
    end
    if (ar_hs)
      ar_addr_q <= araddr_i;
    if (rd_load)
      rdata_q <= rdata_d;  // Frozen for the whole R beat
  end

  // Region decode of the held read address
  always_comb
  begin
    rdata_d = '0;
    if (ar_addr_q < L1_REGION_SIZE)
    begin
      if (rd_idx_o < N_REGS)
        rdata_d = rd_word_i;
    end
    else if (ar_addr_q == MISS_ADDR_REG)
    begin
      if (!miss_empty_i)
        rdata_d[ADDR_WIDTH_VIRT-1:0] = miss_head_i.addr[ADDR_WIDTH_VIRT-1:0];
      rdata_d[MISS_EMPTY_BIT] = miss_empty_i;
    end
    else if (ar_addr_q == MISS_ID_REG)
    begin
      if (!miss_empty_i)
        rdata_d[MISS_ID_WIDTH-1:0] = miss_head_i.id;
      rdata_d[MISS_EMPTY_BIT] = miss_empty_i;
    end
  end

  a_b_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_o && !bready_i |=> bvalid_o)
    else $error("B response withdrawn before its handshake");

  a_r_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
    else $error("R beat withdrawn or changed before its handshake");

endmodule

`default_nettype wire

/* hw/rab_cfg_top.sv */
/* Configuration port of the RAB. Ties the AXI-Lite control, the L1 slice
   table and the miss queue together and sets their parameters. */
`timescale 1ns/1ps
`default_nettype none

module rab_cfg_top #(
  parameter int unsigned N_REGS          = 16,
  parameter int unsigned ADDR_WIDTH_VIRT = 32,
  parameter int unsigned ADDR_WIDTH_PHYS = 40,
  parameter int unsigned N_FLAGS         = 4,
  parameter int unsigned FIFO_DEPTH      = 8
) (
  input  logic                                Clk_CI,
  input  logic                                Rst_RBI,
  input  rab_bus_pkg::axi_addr_t              awaddr_i,
  input  logic                                awvalid_i,
  output logic                                awready_o,
  input  rab_bus_pkg::axi_data_t              wdata_i,
  input  rab_bus_pkg::axi_strb_t              wstrb_i,
  input  logic                                wvalid_i,
  output logic                                wready_o,
  output logic                                bvalid_o,
  output logic [1:0]                          bresp_o,
  input  logic                                bready_i,
  input  rab_bus_pkg::axi_addr_t              araddr_i,
  input  logic                                arvalid_i,
  output logic                                arready_o,
  output logic                                rvalid_o,
  output rab_bus_pkg::axi_data_t              rdata_o,
  output logic [1:0]                          rresp_o,
  input  logic                                rready_i,
  input  logic                                miss_valid_i,
  input  rab_cfg_pkg::miss_entry_t            miss_i,
  output logic                                miss_ready_o,
  output rab_cfg_pkg::cfg_word_u [N_REGS-1:0] l1_cfg_o
);
  import rab_bus_pkg::*;
  import rab_cfg_pkg::*;

  cfg_wr_req_t wr_req;
  cfg_idx_t    rd_idx;
  cfg_word_u   rd_word;
  miss_entry_t miss_head;
  logic        miss_empty;
  logic        miss_pop;

  rab_cfg_axi_ctrl #(
    .N_REGS          (N_REGS),
    .ADDR_WIDTH_VIRT (ADDR_WIDTH_VIRT)
  ) i_axi_ctrl (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .awaddr_i     (awaddr_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .bvalid_o     (bvalid_o),
    .bresp_o      (bresp_o),
    .bready_i     (bready_i),
    .araddr_i     (araddr_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .rready_i     (rready_i),
    .wr_req_o     (wr_req),
    .rd_idx_o     (rd_idx),
    .rd_word_i    (rd_word),
    .miss_head_i  (miss_head),
    .miss_empty_i (miss_empty),
    .miss_pop_o   (miss_pop)
  );

  rab_cfg_regfile #(
    .N_REGS          (N_REGS),
    .ADDR_WIDTH_VIRT (ADDR_WIDTH_VIRT),
    .ADDR_WIDTH_PHYS (ADDR_WIDTH_PHYS),
    .N_FLAGS         (N_FLAGS)
  ) i_regfile (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .wr_req_i  (wr_req),
    .rd_idx_i  (rd_idx),
    .rd_word_o (rd_word),
    .l1_cfg_o  (l1_cfg_o)
  );

  rab_miss_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_miss_fifo (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .miss_valid_i (miss_valid_i),
    .miss_i       (miss_i),
    .miss_ready_o (miss_ready_o),
    .pop_i        (miss_pop),
    .head_o       (miss_head),
    .empty_o      (miss_empty)
  );

endmodule

`default_nettype wire

/* bench/tb_rab_cfg.sv */
/* Self-checking testbench for the RAB configuration port. Drives the AXI-Lite
   slave and the miss input, and checks against a model of slice table and queue. */
`timescale 1ns/1ps
`default_nettype none

module tb_rab_cfg;
  import rab_cfg_pkg::*;

  localparam int N_REGS     = 16;  // DUT defaults
  localparam int VIRT_W     = 32;
  localparam int PHYS_W     = 40;
  localparam int FLAGS_N    = 4;
  localparam int FIFO_DEPTH = 8;
  localparam logic [63:0] EMPTY_WORD = 64'h8000_0000_0000_0000;

  localparam int N_RAND  = 32;
  localparam int N_MISS  = 5;
  localparam int WR_CYC  = 16;  // Write including the longest B stall
  localparam int RD_CYC  = 6;
  localparam int TEST_CYC = 10 + 2 * RD_CYC + N_RAND * (WR_CYC + RD_CYC) + 6 * (WR_CYC + RD_CYC)
                          + (N_MISS + 2 * FIFO_DEPTH + 3) * (3 * RD_CYC + 4) + 9 * WR_CYC;
  localparam int TIMEOUT_CYC = 3 * TEST_CYC;

  logic                   Clk_CI;
  logic                   Rst_RBI;
  logic [31:0]            awaddr_i;
  logic                   awvalid_i;
  logic                   awready_o;
  logic [63:0]            wdata_i;
  logic [7:0]             wstrb_i;
  logic                   wvalid_i;
  logic                   wready_o;
  logic                   bvalid_o;
  logic [1:0]             bresp_o;
  logic                   bready_i;
  logic [31:0]            araddr_i;
  logic                   arvalid_i;
  logic                   arready_o;
  logic                   rvalid_o;
  logic [63:0]            rdata_o;
  logic [1:0]             rresp_o;
  logic                   rready_i;
  logic                   miss_valid_i;
  miss_entry_t            miss_i;
  logic                   miss_ready_o;
  cfg_word_u [N_REGS-1:0] l1_cfg_o;

  int          seed = 67800;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_cnt = 0;
  logic        l1_check_en = 1'b0;
  logic [63:0] exp_mem [N_REGS];
  logic [31:0] mq_addr [$];  // Model of the miss queue
  logic [9:0]  mq_id [$];

  rab_cfg_top UUT (.*);

  initial
  begin
    Clk_CI = 1'b0;
    forever #10 Clk_CI = ~Clk_CI;
  end

  always @(posedge Clk_CI)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYC);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Expected slice word after a strobed write, trimmed to its slot kind
  function automatic logic [63:0] ref_word(input int idx, input logic [63:0] old_w,
                                           input logic [63:0] data, input logic [7:0] strb);
    logic [63:0] merged;
    logic [63:0] keep;
    for (int b = 0; b < 8; b++)
      merged[8*b +: 8] = strb[b] ? data[8*b +: 8] : old_w[8*b +: 8];
    case (idx % 4)
      2:       keep = (64'd1 << PHYS_W) - 64'd1;
      3:       keep = (64'd1 << FLAGS_N) - 64'd1;
      default: keep = (64'd1 << VIRT_W) - 64'd1;  // Index bits 00 and 01
    endcase
    return merged & keep;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Parallel table output against the model
  always @(negedge Clk_CI)
  begin
    if (l1_check_en)
    begin
      for (int i = 0; i < N_REGS; i++)
        check_value($sformatf("l1_cfg_o[%0d]", i), l1_cfg_o[i], exp_mem[i]);
    end
  end

  task automatic send_aw(input logic [31:0] addr);
    awaddr_i  = addr;
    awvalid_i = 1'b1;
    while (!awready_o)
      @(negedge Clk_CI);
    @(negedge Clk_CI);
    awvalid_i = 1'b0;
  endtask

  task automatic send_w(input logic [63:0] data, input logic [7:0] strb);
    wdata_i  = data;
    wstrb_i  = strb;
    wvalid_i = 1'b1;
    while (!wready_o)
      @(negedge Clk_CI);
    @(negedge Clk_CI);
    wvalid_i = 1'b0;
  endtask

  // Order 0 sends AW first, 1 sends W first, 2 sends both together
  task automatic axi_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, input int order, input int b_delay);
    int idx;
    idx = int'(addr[13:3]);
    l1_check_en = 1'b0;
    bready_i = 1'b0;
    if (order == 0 || order == 1)
    begin
      if (order == 0)
        send_aw(addr);
      else
        send_w(data, strb);
      @(negedge Clk_CI);  // Idle gap between the channels
      check_value("bvalid_o", 64'(bvalid_o), 64'd0);
      if (order == 0)
        send_w(data, strb);
      else
        send_aw(addr);
    end
    else
    begin
      awaddr_i  = addr;
      awvalid_i = 1'b1;
      wdata_i   = data;
      wstrb_i   = strb;
      wvalid_i  = 1'b1;
      while (!(awready_o && wready_o))
        @(negedge Clk_CI);
      @(negedge Clk_CI);
      awvalid_i = 1'b0;
      wvalid_i  = 1'b0;
    end
    while (!bvalid_o)
      @(negedge Clk_CI);
    if (addr < L1_REGION_SIZE && idx < N_REGS)
      exp_mem[idx] = ref_word(idx, exp_mem[idx], data, strb);
    l1_check_en = 1'b1;
    repeat (b_delay)
    begin
      @(negedge Clk_CI);
      if (!bvalid_o)
      begin
        errors++;
        $display("B response was withdrawn while bready_i was low");
      end
    end
    check_value("bresp_o", 64'(bresp_o), 64'd0);
    bready_i = 1'b1;
    @(negedge Clk_CI);
    bready_i = 1'b0;
    check_value("bvalid_o", 64'(bvalid_o), 64'd0);  // No second response
    check_value("awready_o", 64'(awready_o), 64'd1);
    check_value("wready_o", 64'(wready_o), 64'd1);
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [63:0] data,
                          output logic [1:0] resp);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    while (!arready_o)
      @(negedge Clk_CI);
    @(negedge Clk_CI);
    arvalid_i = 1'b0;
    while (!rvalid_o)
      @(negedge Clk_CI);
    data = rdata_o;
    resp = rresp_o;
    rready_i = 1'b1;
    @(negedge Clk_CI);
    rready_i = 1'b0;
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [63:0] exp);
    logic [63:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check_value($sformatf("rdata_o from 0x%h", addr), data, exp);
    check_value($sformatf("rresp_o from 0x%h", addr), 64'(resp), 64'd0);
  endtask

  task automatic push_miss(input logic [31:0] addr, input logic [9:0] id);
    miss_i.addr  = addr;
    miss_i.id    = id;
    miss_valid_i = 1'b1;
    while (!miss_ready_o)
      @(negedge Clk_CI);
    @(negedge Clk_CI);
    miss_valid_i = 1'b0;
    mq_addr.push_back(addr);
    mq_id.push_back(id);
  endtask

  // Address reads leave the head alone, ID reads consume it
  task automatic drain_misses();
    logic [63:0] exp_a;
    logic [63:0] exp_id;
    while (mq_addr.size() > 0)
    begin
      exp_a  = {32'h0, mq_addr[0]};
      exp_id = {54'h0, mq_id[0]};
      read_check(MISS_ADDR_REG, exp_a);
      read_check(MISS_ADDR_REG, exp_a);
      read_check(MISS_ID_REG, exp_id);
      void'(mq_addr.pop_front());
      void'(mq_id.pop_front());
    end
    read_check(MISS_ID_REG, EMPTY_WORD);
    read_check(MISS_ADDR_REG, EMPTY_WORD);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before)
      $display("Test %0d %s: pass", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: FAIL with %0d mismatches", tests_run, name, errors - errs_before);
    end
  endtask

  initial
  begin
    int          errs0;
    int          idx;
    logic [31:0] r;
    logic [31:0] a;
    logic [63:0] d;
    Rst_RBI      = 1'b0;
    awaddr_i     = '0;
    awvalid_i    = 1'b0;
    wdata_i      = '0;
    wstrb_i      = '0;
    wvalid_i     = 1'b0;
    bready_i     = 1'b0;
    araddr_i     = '0;
    arvalid_i    = 1'b0;
    rready_i     = 1'b0;
    miss_valid_i = 1'b0;
    miss_i       = '0;
    for (int i = 0; i < N_REGS; i++)
      exp_mem[i] = '0;
    repeat (4) @(posedge Clk_CI);
    @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);

    errs0 = errors;
    check_value("awready_o", 64'(awready_o), 64'd1);
    check_value("wready_o", 64'(wready_o), 64'd1);
    check_value("arready_o", 64'(arready_o), 64'd1);
    check_value("bvalid_o", 64'(bvalid_o), 64'd0);
    check_value("rvalid_o", 64'(rvalid_o), 64'd0);
    l1_check_en = 1'b1;  // Model is all zero after reset
    read_check(MISS_ID_REG, EMPTY_WORD);
    read_check(MISS_ADDR_REG, EMPTY_WORD);
    end_test("reset state", errs0);

    errs0 = errors;
    for (int n = 0; n < N_RAND; n++)
    begin
      r   = rand32();
      idx = int'(r % 32'(N_REGS));
      d   = {rand32(), rand32()};
      r   = rand32();
      axi_write(32'(idx) << WORD_LSB, d, r[7:0], 2, 0);
      read_check(32'(idx) << WORD_LSB, exp_mem[idx]);
    end
    end_test("random strobed writes", errs0);

    errs0 = errors;
    for (int n = 0; n < 6; n++)
    begin
      r   = rand32();
      idx = int'(r % 32'(N_REGS));
      d   = {rand32(), rand32()};
      axi_write(32'(idx) << WORD_LSB, d, 8'hff, n % 3, 1 + int'(r[10:8]));
      read_check(32'(idx) << WORD_LSB, exp_mem[idx]);
    end
    end_test("channel order and B stall", errs0);

    errs0 = errors;
    for (int n = 0; n < N_MISS; n++)
    begin
      r = rand32();
      push_miss(rand32(), r[9:0]);
    end
    drain_misses();
    end_test("miss queue order", errs0);

    errs0 = errors;
    for (int n = 0; n < FIFO_DEPTH; n++)
    begin
      r = rand32();
      push_miss(rand32(), r[9:0]);
    end
    check_value("miss_ready_o", 64'(miss_ready_o), 64'd0);
    a = rand32();
    r = rand32();
    miss_i.addr  = a;
    miss_i.id    = r[9:0];
    miss_valid_i = 1'b1;  // Offered while full
    repeat (3)
    begin
      @(negedge Clk_CI);
      check_value("miss_ready_o", 64'(miss_ready_o), 64'd0);
    end
    read_check(MISS_ID_REG, {54'h0, mq_id[0]});
    void'(mq_addr.pop_front());
    void'(mq_id.pop_front());
    while (!miss_ready_o)
      @(negedge Clk_CI);
    @(negedge Clk_CI);
    miss_valid_i = 1'b0;
    mq_addr.push_back(a);
    mq_id.push_back(r[9:0]);
    drain_misses();
    end_test("full miss queue", errs0);

    errs0 = errors;
    r = rand32();
    d = {rand32(), rand32() | 32'h1};
    axi_write(32'h0, d, 8'hff, 2, 0);  // Nonzero word 0 so an alias would show
    read_check(32'h0000_4010, 64'd0);
    read_check(32'h0000_8000, 64'd0);  // Would alias word 0 without region decode
    read_check(32'h0001_0000, 64'd0);
    read_check(MISS_ID_REG + 32'h8 + {16'h0, r[15:3], 3'b000}, 64'd0);
    axi_write(32'h0000_4010, {rand32(), rand32()}, 8'hff, 2, 0);
    axi_write(32'h0000_8000, {rand32(), rand32()}, 8'hff, 2, 0);
    axi_write(32'h0001_0008, {rand32(), rand32()}, 8'hff, 2, 0);
    for (int i = 0; i < N_REGS; i++)
      check_value($sformatf("l1_cfg_o[%0d]", i), l1_cfg_o[i], exp_mem[i]);
    end_test("unmapped addresses", errs0);

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/rab_bus_pkg.sv
hw/rab_cfg_pkg.sv
hw/rab_fifo_ptr.sv
hw/rab_miss_fifo.sv
hw/rab_cfg_regfile.sv
hw/rab_cfg_axi_ctrl.sv
hw/rab_cfg_top.sv
bench/tb_rab_cfg.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the RAB configuration port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
  -f src.f \
  --top-module tb_rab_cfg \
  -Mdir obj_dir \
  -o Vtb_rab_cfg

./obj_dir/Vtb_rab_cfg | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
